// ==== source/thread_pkg.sv ====
package thread_pkg;

  // bus widths
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int CMD_W       = 32;
  localparam int CMD_CODE_W  = 4;
  localparam int CPU_MSG_W   = 8;
  localparam int THREAD_ID_W = 4;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [CMD_W-1:0]       cmd_t;
  typedef logic [CMD_CODE_W-1:0]  cmd_code_t;
  typedef logic [CPU_MSG_W-1:0]   cpu_msg_t;
  typedef logic [THREAD_ID_W-1:0] thread_id_t;

  // code field occupies the top bits of the command word
  localparam int CMD_CODE_LSB = CMD_W - CMD_CODE_W;

  // command codes
  localparam cmd_code_t CMD_FORK = 4'h1;
  localparam cmd_code_t CMD_STOP = 4'h2;

  // inter-block messages, zero is an idle bus
  localparam cpu_msg_t CPU_MSG_NONE    = 8'h00;
  localparam cpu_msg_t CPU_R_FORK_THRD = 8'h01;
  localparam cpu_msg_t CPU_R_STOP_THRD = 8'h02;
  localparam cpu_msg_t CPU_R_FORK_DONE = 8'h11;
  localparam cpu_msg_t CPU_R_STOP_DONE = 8'h12;

  // bytes in front of a thread entry point
  localparam addr_t THREAD_HEADER_SPACE = 32'd16;

  // thread table geometry
  localparam int THREAD_SLOTS = 8;
  localparam int SLOT_IDX_W   = $clog2(THREAD_SLOTS);

  // id returned on a failed fork or stop
  localparam thread_id_t NO_THREAD = 4'hF;

  // dispatcher service time in enabled cycles
  localparam int DISPATCH_DELAY = 3;
  localparam int DELAY_CNT_W    = $clog2(DISPATCH_DELAY + 1);

  // issue stage steps
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    ALU_BEGIN    = 2'd1,
    FINISH_BEGIN = 2'd2
  } stage_state_e;

endpackage

// ==== source/thread_msg_if.sv ====
`timescale 1ns/10ps

interface thread_msg_if
  import thread_pkg::*;
();

  // controller to dispatcher
  cpu_msg_t   req_msg;
  addr_t      req_addr;
  data_t      req_data;

  // dispatcher to controller
  cpu_msg_t   rsp_msg;
  thread_id_t rsp_id;
  logic       disp_online;

  modport ctlr (
    output req_msg,
    output req_addr,
    output req_data,
    input  rsp_msg,
    input  rsp_id,
    input  disp_online
  );

  modport disp (
    input  req_msg,
    input  req_addr,
    input  req_data,
    output rsp_msg,
    output rsp_id,
    output disp_online
  );

endinterface

// ==== source/cmd_issue.sv ====
`timescale 1ns/10ps

module cmd_issue
  import thread_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         clk_oe,
  input  logic         cmd_start,
  input  cmd_t         command_in,
  input  data_t        src0_in,
  input  data_t        src1_in,
  input  logic         next_state,
  input  thread_id_t   result,
  output stage_state_e state,
  output cmd_t         command,
  output data_t        src0,
  output data_t        src1,
  output logic         busy,
  output logic         done,
  output thread_id_t   dst
);

  stage_state_e state_r;
  logic         accept;

  // one command at a time, only on enabled cycles
  assign accept = clk_oe && cmd_start && (state_r == IDLE);

  // stage walk
  // cycle 0 cmd_start, cycle 1 ALU_BEGIN, hold until next_state,
  // FINISH_BEGIN the cycle after next_state, then back to IDLE
  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= IDLE;
    end else if (clk_oe) begin
      case (state_r)
        IDLE: begin
          if (accept) begin
            state_r <= ALU_BEGIN;
          end
        end
        ALU_BEGIN: begin
          // controller says the command is finished
          if (next_state) begin
            state_r <= FINISH_BEGIN;
          end
        end
        FINISH_BEGIN: begin
          state_r <= IDLE;
        end
        default: begin
          state_r <= IDLE;
        end
      endcase
    end
  end

  // operand and result latches
  always_ff @(posedge clk) begin
    if (accept) begin
      command <= command_in;
      src0    <= src0_in;
      src1    <= src1_in;
    end
    // result valid alongside next_state
    if (clk_oe && (state_r == ALU_BEGIN) && next_state) begin
      dst <= result;
    end
  end

  assign state = state_r;
  assign busy  = (state_r != IDLE);

  // done pulse for the single FINISH_BEGIN cycle, low on stalled cycles
  assign done = clk_oe && (state_r == FINISH_BEGIN);

  // a second command must wait for busy to drop
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (rst)
    (clk_oe && busy) |-> !cmd_start
  ) else $error("cmd_issue: cmd_start while busy");

endmodule

// ==== source/thread_ctlr.sv ====
`timescale 1ns/10ps

module thread_ctlr
  import thread_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         clk_oe,
  input  stage_state_e state,
  input  cmd_t         command,
  input  data_t        src0,
  input  data_t        src1,
  input  addr_t        base_addr,
  input  addr_t        base_addr_data,
  thread_msg_if.ctlr   msg,
  output logic         next_state,
  output thread_id_t   dst
);

  cmd_code_t  cmd_code;
  logic       is_fork;
  logic       is_stop;
  logic       is_thread_cmd;
  cpu_msg_t   req_code;
  cpu_msg_t   done_code;
  addr_t      req_addr_c;
  data_t      req_data_c;
  logic       signal_sent;
  logic       send;
  logic       reply_match;
  logic       reply_r;
  thread_id_t dst_r;

  // code field decode
  assign cmd_code      = command[CMD_CODE_LSB +: CMD_CODE_W];
  assign is_fork       = (cmd_code == CMD_FORK);
  assign is_stop       = (cmd_code == CMD_STOP);
  assign is_thread_cmd = is_fork || is_stop;

  // request payload and the reply we expect back
  always_comb begin
    req_code   = CPU_MSG_NONE;
    done_code  = CPU_MSG_NONE;
    req_addr_c = src0 + base_addr;
    // null argument stays null
    req_data_c = (src1 == '0) ? '0 : src1 + base_addr_data;
    if (is_fork) begin
      req_code  = CPU_R_FORK_THRD;
      done_code = CPU_R_FORK_DONE;
    end else if (is_stop) begin
      req_code   = CPU_R_STOP_THRD;
      done_code  = CPU_R_STOP_DONE;
      // stop names the thread header, not the entry
      req_addr_c = src0 + base_addr - THREAD_HEADER_SPACE;
      req_data_c = (src1 == '0) ? '0 : src1 + base_addr_data - THREAD_HEADER_SPACE;
    end
  end

  // first ALU_BEGIN cycle with the dispatcher free
  assign send = clk_oe && (state == ALU_BEGIN) && is_thread_cmd
             && msg.disp_online && !signal_sent;

  // request bus idles at zero
  assign msg.req_msg  = send ? req_code   : CPU_MSG_NONE;
  assign msg.req_addr = send ? req_addr_c : '0;
  assign msg.req_data = send ? req_data_c : '0;

  // matching reply to our outstanding request
  assign reply_match = clk_oe && (state == ALU_BEGIN) && is_thread_cmd
                    && signal_sent && (msg.rsp_msg == done_code);

  always_ff @(posedge clk) begin
    if (rst) begin
      signal_sent <= 1'b0;
      reply_r     <= 1'b0;
    end else if (clk_oe) begin
      // next_state follows the reply by one cycle
      reply_r <= reply_match;
      // stays set through the reply so nothing is resent
      if (state != ALU_BEGIN) begin
        signal_sent <= 1'b0;
      end else if (send) begin
        signal_sent <= 1'b1;
      end
    end
  end

  // slot id from the dispatcher
  always_ff @(posedge clk) begin
    if (reply_match) begin
      dst_r <= msg.rsp_id;
    end
  end

  // unknown codes finish at once
  assign next_state = clk_oe
                   && (reply_r || ((state == ALU_BEGIN) && !is_thread_cmd));
  assign dst = is_thread_cmd ? dst_r : NO_THREAD;

  // dispatcher only answers a request we actually sent
  a_reply_only_outstanding: assert property (
    @(posedge clk) disable iff (rst)
    (msg.rsp_msg != CPU_MSG_NONE) |-> signal_sent
  ) else $error("thread_ctlr: reply with no request outstanding");

endmodule

// ==== source/thread_dispatcher.sv ====
`timescale 1ns/10ps

module thread_dispatcher
  import thread_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clk_oe,
  input  logic       disp_enable,
  thread_msg_if.disp msg,
  input  thread_id_t query_slot,
  output logic [3:0] thread_count,
  output addr_t      query_entry,
  output data_t      query_arg,
  output logic       query_valid
);

  // thread table
  logic [THREAD_SLOTS-1:0] slot_valid;
  addr_t                   slot_entry [THREAD_SLOTS];
  data_t                   slot_arg   [THREAD_SLOTS];

  // request in service
  logic                   in_service;
  logic [DELAY_CNT_W-1:0] delay_cnt;
  cpu_msg_t               pend_msg;
  addr_t                  pend_addr;
  data_t                  pend_data;
  logic                   take_req;
  logic                   fire;

  // slot search results
  logic                  free_found;
  logic [SLOT_IDX_W-1:0] free_idx;
  logic                  match_found;
  logic [SLOT_IDX_W-1:0] match_idx;

  // reply registers
  cpu_msg_t   rsp_msg_r;
  thread_id_t rsp_id_r;

  logic [SLOT_IDX_W-1:0] query_idx;
  logic                  query_in_range;

  assign take_req = clk_oe && msg.disp_online
                 && ((msg.req_msg == CPU_R_FORK_THRD) || (msg.req_msg == CPU_R_STOP_THRD));

  // last service cycle, reply shows up next cycle
  assign fire = clk_oe && in_service && (delay_cnt == DELAY_CNT_W'(1));

  // lowest free slot and lowest matching header
  always_comb begin
    free_found  = 1'b0;
    free_idx    = '0;
    match_found = 1'b0;
    match_idx   = '0;
    // scan high to low so the lowest index wins
    for (int i = THREAD_SLOTS - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_found = 1'b1;
        free_idx   = SLOT_IDX_W'(i);
      end
      if (slot_valid[i] && ((slot_entry[i] - THREAD_HEADER_SPACE) == pend_addr)) begin
        match_found = 1'b1;
        match_idx   = SLOT_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_service <= 1'b0;
      delay_cnt  <= '0;
      pend_msg   <= CPU_MSG_NONE;
      rsp_msg_r  <= CPU_MSG_NONE;
      slot_valid <= '0;
    end else if (clk_oe) begin
      rsp_msg_r <= CPU_MSG_NONE;
      if (take_req) begin
        in_service <= 1'b1;
        delay_cnt  <= DELAY_CNT_W'(DISPATCH_DELAY - 1);
        pend_msg   <= msg.req_msg;
      end else if (fire) begin
        in_service <= 1'b0;
        if (pend_msg == CPU_R_FORK_THRD) begin
          rsp_msg_r <= CPU_R_FORK_DONE;
          if (free_found) begin
            slot_valid[free_idx] <= 1'b1;
          end
        end else begin
          rsp_msg_r <= CPU_R_STOP_DONE;
          if (match_found) begin
            slot_valid[match_idx] <= 1'b0;
          end
        end
      end else if (in_service) begin
        delay_cnt <= delay_cnt - 1'b1;
      end
    end
  end

  // slot contents and reply id
  always_ff @(posedge clk) begin
    if (take_req) begin
      pend_addr <= msg.req_addr;
      pend_data <= msg.req_data;
    end
    if (fire) begin
      if (pend_msg == CPU_R_FORK_THRD) begin
        if (free_found) begin
          slot_entry[free_idx] <= pend_addr;
          slot_arg[free_idx]   <= pend_data;
        end
        rsp_id_r <= free_found ? thread_id_t'(free_idx) : NO_THREAD;
      end else begin
        rsp_id_r <= match_found ? thread_id_t'(match_idx) : NO_THREAD;
      end
    end
  end

  assign msg.rsp_msg     = clk_oe ? rsp_msg_r : CPU_MSG_NONE;
  assign msg.rsp_id      = rsp_id_r;
  assign msg.disp_online = disp_enable && !in_service;

  // live thread count
  always_comb begin
    thread_count = '0;
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      thread_count = thread_count + 4'(slot_valid[i]);
    end
  end

  // query port, ids past the table read empty
  assign query_idx      = query_slot[SLOT_IDX_W-1:0];
  assign query_in_range = (query_slot < THREAD_SLOTS);
  assign query_valid    = query_in_range && slot_valid[query_idx];
  assign query_entry    = query_in_range ? slot_entry[query_idx] : '0;
  assign query_arg      = query_in_range ? slot_arg[query_idx] : '0;

  // controller never overlaps requests
  a_one_req_in_flight: assert property (
    @(posedge clk) disable iff (rst)
    (clk_oe && (msg.req_msg != CPU_MSG_NONE)) |-> !in_service
  ) else $error("thread_dispatcher: request while busy");

endmodule

// ==== source/thread_unit_top.sv ====
`timescale 1ns/10ps

module thread_unit_top
  import thread_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clk_oe,
  input  logic       disp_enable,
  input  logic       cmd_start,
  input  cmd_t       command,
  input  data_t      src0,
  input  data_t      src1,
  input  addr_t      base_addr,
  input  addr_t      base_addr_data,
  input  thread_id_t query_slot,
  output logic       busy,
  output logic       done,
  output thread_id_t dst,
  output logic [3:0] thread_count,
  output addr_t      query_entry,
  output data_t      query_arg,
  output logic       query_valid
);

  // issue stage to controller
  stage_state_e stage;
  cmd_t         cmd_l;
  data_t        src0_l;
  data_t        src1_l;
  logic         next_state;
  thread_id_t   result;

  // controller to dispatcher
  thread_msg_if msg_bus ();

  cmd_issue u_issue (
    .clk        (clk),
    .rst        (rst),
    .clk_oe     (clk_oe),
    .cmd_start  (cmd_start),
    .command_in (command),
    .src0_in    (src0),
    .src1_in    (src1),
    .next_state (next_state),
    .result     (result),
    .state      (stage),
    .command    (cmd_l),
    .src0       (src0_l),
    .src1       (src1_l),
    .busy       (busy),
    .done       (done),
    .dst        (dst)
  );

  thread_ctlr u_ctlr (
    .clk            (clk),
    .rst            (rst),
    .clk_oe         (clk_oe),
    .state          (stage),
    .command        (cmd_l),
    .src0           (src0_l),
    .src1           (src1_l),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .msg            (msg_bus.ctlr),
    .next_state     (next_state),
    .dst            (result)
  );

  thread_dispatcher u_disp (
    .clk          (clk),
    .rst          (rst),
    .clk_oe       (clk_oe),
    .disp_enable  (disp_enable),
    .msg          (msg_bus.disp),
    .query_slot   (query_slot),
    .thread_count (thread_count),
    .query_entry  (query_entry),
    .query_arg    (query_arg),
    .query_valid  (query_valid)
  );

endmodule

// ==== test/tb_thread_model.svh ====
`ifndef TB_THREAD_MODEL_SVH
`define TB_THREAD_MODEL_SVH

// expected outcome of one command
typedef struct packed {
  thread_id_t id;
  addr_t      entry;
  data_t      arg;
  logic       live;
  logic [3:0] count;
} expect_t;

// mirror of the dispatcher table
logic  m_valid [THREAD_SLOTS];
addr_t m_entry [THREAD_SLOTS];
data_t m_arg   [THREAD_SLOTS];

function automatic void model_clear();
  for (int i = 0; i < THREAD_SLOTS; i++) begin
    m_valid[i] = 1'b0;
    m_entry[i] = '0;
    m_arg[i]   = '0;
  end
endfunction

function automatic logic [3:0] model_count();
  logic [3:0] n;
  n = '0;
  for (int i = 0; i < THREAD_SLOTS; i++) begin
    if (m_valid[i]) begin
      n = n + 4'd1;
    end
  end
  return n;
endfunction

// applies one command to the table and returns what the DUT should report
function automatic expect_t model_apply(cmd_code_t code, data_t s0, data_t s1,
                                        addr_t base, addr_t base_data);
  expect_t e;
  addr_t   hdr;
  bit      found;
  e.id    = NO_THREAD;
  e.entry = '0;
  e.arg   = '0;
  e.live  = 1'b0;
  found   = 1'b0;
  if (code == CMD_FORK) begin
    // lowest free slot wins
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      if (!found && !m_valid[i]) begin
        found      = 1'b1;
        m_valid[i] = 1'b1;
        m_entry[i] = s0 + base;
        // a null argument pointer stays null
        m_arg[i]   = (s1 == '0) ? '0 : s1 + base_data;
        e.id       = thread_id_t'(i);
        e.entry    = m_entry[i];
        e.arg      = m_arg[i];
        e.live     = 1'b1;
      end
    end
  end else if (code == CMD_STOP) begin
    // stop names the header in front of the entry point
    hdr = s0 + base - THREAD_HEADER_SPACE;
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      if (!found && m_valid[i] && ((m_entry[i] - THREAD_HEADER_SPACE) == hdr)) begin
        found      = 1'b1;
        e.id       = thread_id_t'(i);
        m_valid[i] = 1'b0;
      end
    end
  end
  e.count = model_count();
  return e;
endfunction

`endif

// ==== test/tb_thread_unit.sv ====
`timescale 1ns/10ps

module tb_thread_unit
  import thread_pkg::*;
();

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 2;
  localparam int          NUM_DIRECTED   = 12;
  localparam int          NUM_RANDOM     = 48;
  localparam int          NUM_CMDS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int          CYCLES_PER_CMD = 40;
  localparam int unsigned RAND_SEED      = 32'h99ae1412;
  // cmd_start, request, service delay, reply, next_state, done
  localparam int          FORK_LATENCY   = DISPATCH_DELAY + 4;

  logic       clk;
  logic       rst;
  logic       clk_oe;
  logic       disp_enable;
  logic       cmd_start;
  cmd_t       command;
  data_t      src0;
  data_t      src1;
  addr_t      base_addr;
  addr_t      base_addr_data;
  thread_id_t query_slot;
  logic       busy;
  logic       done;
  thread_id_t dst;
  logic [3:0] thread_count;
  addr_t      query_entry;
  data_t      query_arg;
  logic       query_valid;

  `include "tb_thread_model.svh"

  // results still owed by the DUT, oldest first
  expect_t exp_q [$];
  bit      random_mode;
  int      cmds_issued;

  thread_unit_top UUT (
    .clk            (clk),
    .rst            (rst),
    .clk_oe         (clk_oe),
    .disp_enable    (disp_enable),
    .cmd_start      (cmd_start),
    .command        (command),
    .src0           (src0),
    .src1           (src1),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .query_slot     (query_slot),
    .busy           (busy),
    .done           (done),
    .dst            (dst),
    .thread_count   (thread_count),
    .query_entry    (query_entry),
    .query_arg      (query_arg),
    .query_valid    (query_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_id(input string name, input thread_id_t got, input thread_id_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // null argument about one time in four
  function automatic data_t random_arg();
    data_t v;
    v = $urandom();
    if (($urandom() % 4) == 0) begin
      v = '0;
    end
    return v;
  endfunction

  // any code the controller should reject
  function automatic cmd_code_t other_code();
    cmd_code_t c;
    do begin
      c = cmd_code_t'($urandom() % 16);
    end while ((c == CMD_FORK) || (c == CMD_STOP));
    return c;
  endfunction

  // random live slot, NO_THREAD on an empty table
  function automatic thread_id_t random_live_slot();
    int n;
    int k;
    n = model_count();
    if (n == 0) begin
      return NO_THREAD;
    end
    k = $urandom() % n;
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      if (m_valid[i]) begin
        if (k == 0) begin
          return thread_id_t'(i);
        end
        k--;
      end
    end
    return NO_THREAD;
  endfunction

  // reads one slot through the query port
  task automatic check_slot(input thread_id_t slot);
    @(negedge clk);
    query_slot = slot;
    @(posedge clk);
    compare_flag("query_valid", query_valid, m_valid[slot]);
    if (m_valid[slot]) begin
      compare_addr("query_entry", query_entry, m_entry[slot]);
      compare_data("query_arg", query_arg, m_arg[slot]);
    end
  endtask

  // issues one command and waits for done
  // cycles counts the cmd_start cycle through the done cycle
  task automatic run_cmd(input cmd_code_t code, input data_t s0, input data_t s1,
                         output expect_t e, output int cycles);
    logic [31:0] low_bits;
    e = model_apply(code, s0, s1, base_addr, base_addr_data);
    exp_q.push_back(e);
    cmds_issued++;
    low_bits = $urandom();
    @(negedge clk);
    command    = {code, low_bits[CMD_CODE_LSB-1:0]};
    src0       = s0;
    src1       = s1;
    // query port watches the slot this command should touch
    query_slot = e.id;
    cmd_start  = 1'b1;
    // held until an enabled edge takes it
    @(posedge clk);
    while (!clk_oe) begin
      @(posedge clk);
    end
    cycles = 1;
    @(negedge clk);
    cmd_start = 1'b0;
    compare_flag("busy", busy, 1'b1);
    do begin
      @(posedge clk);
      cycles++;
    end while (!done);
    // compare process has seen this done by now
    @(negedge clk);
    compare_flag("busy", busy, 1'b0);
  endtask

  // random stalls, only during the random phase
  initial begin : enable_toggler
    forever begin
      @(negedge clk);
      if (random_mode) begin
        clk_oe      = (($urandom() % 4) != 0);
        disp_enable = (($urandom() % 2) != 0);
      end else begin
        clk_oe      = 1'b1;
        disp_enable = 1'b1;
      end
    end
  end

  // checks dst, the count and the touched slot on every done pulse
  initial begin : compare_proc
    expect_t exp;
    wait (rst === 1'b0);
    forever begin
      @(posedge clk);
      if (done) begin
        if (exp_q.size() == 0) begin
          fail_now("done pulsed with no command outstanding");
        end else begin
          exp = exp_q.pop_front();
          compare_id("dst", dst, exp.id);
          compare_count("thread_count", thread_count, exp.count);
          if (exp.id != NO_THREAD) begin
            compare_flag("query_valid", query_valid, exp.live);
            if (exp.live) begin
              compare_addr("query_entry", query_entry, exp.entry);
              compare_data("query_arg", query_arg, exp.arg);
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + NUM_CMDS * CYCLES_PER_CMD) @(posedge clk);
    fail_now($sformatf("done never arrived, watchdog expired during command %0d of %0d",
                       cmds_issued, NUM_CMDS));
  end

  initial begin : stimulus
    expect_t     e;
    int          cycles;
    int unsigned seed_dummy;
    data_t       s0;
    data_t       s1;
    data_t       stop_src0;
    thread_id_t  live;
    int          pick;

    rst            = 1'b1;
    clk_oe         = 1'b1;
    disp_enable    = 1'b1;
    cmd_start      = 1'b0;
    command        = '0;
    src0           = '0;
    src1           = '0;
    base_addr      = '0;
    base_addr_data = '0;
    query_slot     = '0;
    random_mode    = 1'b0;
    cmds_issued    = 0;
    seed_dummy     = $urandom(RAND_SEED);
    base_addr      = $urandom();
    base_addr_data = $urandom();
    model_clear();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    compare_flag("busy", busy, 1'b0);
    compare_flag("done", done, 1'b0);
    compare_count("thread_count", thread_count, 4'd0);

    // fork with an argument goes to slot 0
    s0 = $urandom();
    s1 = $urandom() | 32'h1;
    run_cmd(CMD_FORK, s0, s1, e, cycles);
    check_slot(e.id);

    // null argument, and the fixed latency
    run_cmd(CMD_FORK, $urandom(), '0, e, cycles);
    check_slot(e.id);
    if (cycles != FORK_LATENCY) begin
      fail_now($sformatf("fork took %0d cycles from cmd_start to done, expected %0d",
                         cycles, FORK_LATENCY));
    end

    // fill the table
    for (int i = 2; i < THREAD_SLOTS; i++) begin
      run_cmd(CMD_FORK, $urandom(), random_arg(), e, cycles);
      check_slot(e.id);
    end

    // ninth fork bounces
    run_cmd(CMD_FORK, $urandom(), random_arg(), e, cycles);

    // free slot 3 by its entry, then retry the stale address
    stop_src0 = m_entry[3] - base_addr;
    run_cmd(CMD_STOP, stop_src0, $urandom(), e, cycles);
    check_slot(thread_id_t'(3));
    run_cmd(CMD_STOP, stop_src0, '0, e, cycles);

    // unknown code leaves the table alone
    run_cmd(4'h7, $urandom(), $urandom(), e, cycles);
    check_slot(thread_id_t'(0));

    // random mix with stalls on clk_oe and disp_enable
    random_mode = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      pick = $urandom() % 8;
      s0   = $urandom();
      s1   = random_arg();
      if (pick < 4) begin
        run_cmd(CMD_FORK, s0, s1, e, cycles);
      end else if (pick < 6) begin
        live = random_live_slot();
        if (live != NO_THREAD) begin
          s0 = m_entry[live] - base_addr;
        end
        run_cmd(CMD_STOP, s0, s1, e, cycles);
      end else if (pick == 6) begin
        run_cmd(CMD_STOP, s0, s1, e, cycles);
      end else begin
        run_cmd(other_code(), s0, s1, e, cycles);
      end
      check_slot(thread_id_t'($urandom() % THREAD_SLOTS));
    end
    random_mode = 1'b0;
    @(negedge clk);

    if (exp_q.size() != 0) begin
      fail_now($sformatf("%0d results never came back from the DUT", exp_q.size()));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== build.f ====
source/thread_pkg.sv
source/thread_msg_if.sv
source/cmd_issue.sv
source/thread_ctlr.sv
source/thread_dispatcher.sv
source/thread_unit_top.sv
+incdir+test
test/tb_thread_unit.sv
